// ==== flist.f ====
+incdir+common
common/gate_pkg.sv
hw/gate_sequencer.sv
hw/gate_lane/gate_lane_mac.sv
hw/gate_tanh/gate_tanh_collector.sv
hw/activation_gate_top.sv
verif/activation_gate_assert.sv
verif/activation_gate_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the activation gate testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
  --top-module activation_gate_tb -o sim_activation_gate > build.log 2>&1 \
  || { cat build.log; echo "build error, see build.log"; exit 1; }

./obj_dir/sim_activation_gate +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== verif/activation_gate_tb.sv ====
// Activation gate testbench; results come back in order and the run ends at a fixed cycle limit
`timescale 1ns/1ps
`default_nettype none

`include "gate_defines.svh"

module activation_gate_tb;

  localparam int LANES = `GATE_LANES;
  localparam int FRAC  = `GATE_FRAC;
  localparam int LIMIT = 16 + 14 * 24 + 1000;  // Reset, 14 vectors of up to 24 cycles, margin

  logic                 CLK;
  logic                 RST;
  logic                 start;
  gate_pkg::gate_vec_t  bias;
  logic                 term_valid;
  gate_pkg::term_beat_t term;
  logic                 busy;
  logic                 a_valid;
  gate_pkg::gate_vec_t  a_out;

  int                   seed;
  int                   errors;       // Value check failures
  int                   tests_run;
  int                   test_base;    // Failures before the current test
  int                   cycles;
  string                cur_test;
  longint               acc_m [LANES];  // Model accumulators
  gate_pkg::gate_vec_t  exp_q [$];      // Expected vectors in order

  always #2 CLK = ~CLK;  // 4 ns period

  activation_gate_top i_activation_gate_top (
    .CLK(CLK), .RST(RST), .start(start), .bias(bias), .term_valid(term_valid),
    .term(term), .busy(busy), .a_valid(a_valid), .a_out(a_out)
  );

  bind activation_gate_top activation_gate_assert i_activation_gate_assert (
    .CLK(CLK), .RST(RST), .term_valid(term_valid), .term(term),
    .busy(busy), .a_valid(a_valid), .a_out(a_out)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Back to Q8.8 then clamp to the word
  function automatic longint rescale_sat(input longint acc);
    longint r;
    r = acc >>> FRAC;
    if (r > 32767) r = 32767;
    else if (r < -32768) r = -32768;
    return r;
  endfunction

  // Three segments on the magnitude with the sign copied back
  function automatic gate_pkg::gate_data_t expect_tanh(input longint s);
    longint m;
    longint y;
    m = (s < 0) ? -s : s;
    if (m < (longint'(1) << (FRAC - 1))) y = m;                       // Below 0.5
    else if (m < (longint'(3) << (FRAC - 1))) y = (m >> 1) + (longint'(1) << (FRAC - 2));
    else y = longint'(1) << FRAC;                                      // 1.0
    return gate_pkg::gate_data_t'((s < 0) ? -y : y);
  endfunction

  function automatic gate_pkg::gate_data_t rand_word(input int shift);
    gate_pkg::gate_data_t r;
    r = gate_pkg::gate_data_t'($random(seed));
    return r >>> shift;  // Smaller range for larger shift
  endfunction

  function automatic gate_pkg::gate_vec_t vec4(input gate_pkg::gate_data_t e0, e1, e2, e3);
    gate_pkg::gate_vec_t v;
    v = '0;
    v[0] = e0;
    v[1] = e1;
    v[2] = e2;
    v[3] = e3;
    return v;
  endfunction

  function automatic int total_fail();
    return errors + i_activation_gate_top.i_activation_gate_assert.fail_count;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // counted is low for strobes the DUT must drop
  task automatic drive_start(input gate_pkg::gate_vec_t b, input bit counted);
    @(posedge CLK);
    start      <= 1'b1;
    bias       <= b;
    term_valid <= 1'b0;
    if (counted) for (int i = 0; i < LANES; i++) acc_m[i] = longint'(b[i]) <<< FRAC;
  endtask

  task automatic drive_beat(input gate_pkg::gate_data_t bx, input gate_pkg::gate_vec_t bw,
                            input bit blast, input bit counted);
    gate_pkg::gate_vec_t ev;
    @(posedge CLK);
    start      <= 1'b0;
    term_valid <= 1'b1;
    term       <= '{x: bx, weights: bw, last: blast};
    if (counted) begin
      for (int i = 0; i < LANES; i++) acc_m[i] += longint'(bx) * longint'(bw[i]);
      if (blast) begin
        for (int i = 0; i < LANES; i++) ev[i] = expect_tanh(rescale_sat(acc_m[i]));
        exp_q.push_back(ev);
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      start      <= 1'b0;
      term_valid <= 1'b0;
    end
  endtask

  task automatic check_word(input int lane, input gate_pkg::gate_data_t e, a);
    if (a !== e) begin
      $display("MISMATCH test=%s lane=%0d expected=%h actual=%h", cur_test, lane, e, a);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_base = total_fail();
  endtask

  task automatic end_test();
    idle(1);
    while (exp_q.size() > 0) idle(1);  // Drain pending results
    idle(2);
    tests_run++;
    $display("test %-12s done, %0d errors", cur_test, total_fail() - test_base);
  endtask

  //////////////////////////////////////////////////
  // Result monitor and timeout
  //////////////////////////////////////////////////

  always @(posedge CLK) begin : monitor
    gate_pkg::gate_vec_t ev;
    if (!RST && a_valid) begin
      if (exp_q.size() == 0) begin
        $display("%s: a_valid arrived with no result pending", cur_test);
        errors++;
      end else begin
        ev = exp_q.pop_front();
        for (int i = 0; i < LANES; i++) check_word(i, ev[i], a_out[i]);
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    gate_pkg::gate_vec_t  b;
    gate_pkg::gate_vec_t  w;
    gate_pkg::gate_data_t x;
    int                   nbeats;
    CLK        = 1'b0;
    RST        = 1'b1;
    start      = 1'b0;
    bias       = '0;
    term_valid = 1'b0;
    term       = '0;
    seed       = 97253;
    errors     = 0;
    tests_run  = 0;
    cycles     = 0;
    test_base  = 0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    begin_test("reset");
    @(negedge CLK);
    if (busy !== 1'b0) begin
      $display("MISMATCH test=%s busy expected=0 actual=%b", cur_test, busy);
      errors++;
    end
    if (a_valid !== 1'b0) begin
      $display("MISMATCH test=%s a_valid expected=0 actual=%b", cur_test, a_valid);
      errors++;
    end
    for (int i = 0; i < LANES; i++) check_word(i, '0, a_out[i]);
    end_test();

    begin_test("single_term");  // 0.5 times small weights
    drive_start('0, 1'b1);
    drive_beat(16'sh0080, vec4(16'sh0040, 16'sh0020, -16'sh0030, 16'sh0010), 1'b1, 1'b1);
    end_test();

    begin_test("random_acc");
    for (int v = 0; v < 8; v++) begin
      nbeats = 4 + int'({$random(seed)} % 5);
      for (int i = 0; i < LANES; i++) b[i] = rand_word((v % 2) ? 0 : 6);  // Odd ones saturate
      drive_start(b, 1'b1);
      for (int k = 0; k < nbeats; k++) begin
        x = rand_word((v % 2) ? 0 : 6);
        for (int i = 0; i < LANES; i++) w[i] = rand_word((v % 2) ? 0 : 6);
        drive_beat(x, w, k == nbeats - 1, 1'b1);
      end
      idle(1);
    end
    end_test();

    begin_test("tanh_segs");  // x of 1.0 passes weights through
    drive_start('0, 1'b1);
    drive_beat(16'sh0100, vec4(16'sh0040, 16'sh0080, 16'sh00c0, 16'sh0180), 1'b1, 1'b1);
    idle(1);
    drive_start('0, 1'b1);
    drive_beat(16'sh0100, vec4(-16'sh0080, -16'sh0180, -16'sh00c0, 16'sh017f), 1'b1, 1'b1);
    end_test();

    begin_test("ignored");
    drive_beat(16'sh0100, vec4(16'sh0100, 16'sh0100, 16'sh0100, 16'sh0100), 1'b1, 1'b0);
    idle(1);
    drive_start(vec4(16'sh0010, 16'sh0020, -16'sh0010, 16'sh0000), 1'b1);
    drive_beat(16'sh0040, vec4(16'sh0100, -16'sh0080, 16'sh0040, 16'sh0200), 1'b0, 1'b1);
    drive_start(vec4(16'sh0700, 16'sh0700, 16'sh0700, 16'sh0700), 1'b0);  // While busy
    drive_beat(16'sh0020, vec4(16'sh0080, 16'sh0080, -16'sh0100, 16'sh0040), 1'b1, 1'b1);
    end_test();

    begin_test("back_to_back");
    drive_start(vec4(16'sh0020, -16'sh0020, 16'sh0000, 16'sh0050), 1'b1);
    drive_beat(16'sh0080, vec4(16'sh0100, 16'sh0080, -16'sh0200, 16'sh0040), 1'b1, 1'b1);
    drive_start(vec4(-16'sh0030, 16'sh0010, 16'sh0060, 16'sh0000), 1'b1);  // Cycle after last
    drive_beat(16'sh0100, vec4(16'sh0020, 16'sh0300, -16'sh0040, 16'sh0090), 1'b0, 1'b1);
    drive_beat(-16'sh0040, vec4(16'sh0100, 16'sh0100, 16'sh0100, -16'sh0100), 1'b1, 1'b1);
    end_test();

    $display("tests %0d, value errors %0d, assertion failures %0d", tests_run, errors,
             i_activation_gate_top.i_activation_gate_assert.fail_count);
    if (total_fail() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/activation_gate_assert.sv ====
// Timing and reset checks bound to activation_gate_top; fail_count holds the number of failed checks
`timescale 1ns/1ps
`default_nettype none

module activation_gate_assert (
  input wire logic                  CLK,
  input wire logic                  RST,
  input wire logic                  term_valid,
  input wire gate_pkg::term_beat_t  term,
  input wire logic                  busy,
  input wire logic                  a_valid,
  input wire gate_pkg::gate_vec_t   a_out
);

  int   fail_count = 0;  // Read at the end of the run
  logic last_beat;       // Edge that takes the final term

  assign last_beat = busy && term_valid && term.last;

  //////////////////////////////////////////////////
  // Result timing
  //////////////////////////////////////////////////

  // Sequencer, lane and collector registers lie between the beat and a sampled a_valid
  a_valid_due: assert property (@(posedge CLK) disable iff (RST)
    $past(last_beat, 3) |-> a_valid)
    else begin
      fail_count++;
      $error("a_valid missing two cycles after last beat");
    end

  a_valid_spurious: assert property (@(posedge CLK) disable iff (RST)
    a_valid |-> $past(last_beat, 3))
    else begin
      fail_count++;
      $error("a_valid without a last beat two cycles before");
    end

  // Busy drops only on the edge of the last beat
  busy_fall: assert property (@(posedge CLK) disable iff (RST)
    $fell(busy) |-> $past(last_beat))
    else begin
      fail_count++;
      $error("busy fell without a last beat");
    end

  // Held reset clears every output
  reset_state: assert property (@(posedge CLK)
    ($past(RST) && RST) |-> (!busy && !a_valid && a_out == '0))
    else begin
      fail_count++;
      $error("outputs not cleared in reset");
    end

endmodule

`default_nettype wire

// ==== hw/activation_gate_top.sv ====
// Activation gate top; a_valid comes two cycles after the last beat and must be taken when it pulses
`timescale 1ns/1ps
`default_nettype none

`include "gate_defines.svh"

module activation_gate_top (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire gate_pkg::gate_vec_t   bias,
  input  wire logic                  term_valid,
  input  wire gate_pkg::term_beat_t  term,
  output logic                       busy,
  output logic                       a_valid,
  output gate_pkg::gate_vec_t        a_out
);

  gate_pkg::lane_cmd_t      cmd;         // Broadcast to all lanes
  gate_pkg::gate_vec_t      bias_q;
  gate_pkg::gate_vec_t      lane_res;    // One word per lane
  logic [`GATE_LANES-1:0]   lane_valid;  // Aligned across lanes

  //////////////////////////////////////////////////
  // Feed
  //////////////////////////////////////////////////

  gate_sequencer i_gate_sequencer (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .bias       (bias),
    .term_valid (term_valid),
    .term       (term),
    .busy       (busy),
    .cmd        (cmd),
    .bias_q     (bias_q)
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `GATE_LANES; i++) begin : g_lane
    gate_lane_mac #(
      .LANE_IDX (i)
    ) i_gate_lane_mac (
      .CLK        (CLK),
      .RST        (RST),
      .cmd        (cmd),
      .bias_q     (bias_q),
      .lane_res   (lane_res[i]),
      .lane_valid (lane_valid[i])
    );
  end

  //////////////////////////////////////////////////
  // Drain
  //////////////////////////////////////////////////

  gate_tanh_collector i_gate_tanh_collector (
    .CLK        (CLK),
    .RST        (RST),
    .lane_res   (lane_res),
    .lane_valid (lane_valid[0]),  // Lane 0 stands for all
    .a_out      (a_out),
    .a_valid    (a_valid)
  );

endmodule

`default_nettype wire

// ==== hw/gate_tanh/gate_tanh_collector.sv ====
// Piecewise-linear tanh on all lanes; lanes must be aligned since only lane 0's valid is tested
`timescale 1ns/1ps
`default_nettype none

`include "gate_defines.svh"

module gate_tanh_collector (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire gate_pkg::gate_vec_t  lane_res,
  input  wire logic                 lane_valid,  // From lane 0
  output gate_pkg::gate_vec_t       a_out,
  output logic                      a_valid      // One-cycle pulse
);

  localparam int DATA_W = `GATE_DATA_W;
  localparam int FRAC   = `GATE_FRAC;

  //////////////////////////////////////////////////
  // Segment constants in Q8.8
  //////////////////////////////////////////////////

  localparam logic [DATA_W:0] TH_LOW  = (DATA_W+1)'(1 << (FRAC-1));  // 0.5
  localparam logic [DATA_W:0] TH_HIGH = (DATA_W+1)'(3 << (FRAC-1));  // 1.5
  localparam logic [DATA_W:0] Y_ONE   = (DATA_W+1)'(1 << FRAC);
  localparam logic [DATA_W:0] Y_QUART = (DATA_W+1)'(1 << (FRAC-2));  // Offset of mid segment

  // Three segments on the magnitude then sign restored
  function automatic gate_pkg::gate_data_t tanh_pwl(input gate_pkg::gate_data_t v);
    logic            neg;
    logic [DATA_W:0] v_ext;
    logic [DATA_W:0] mag;  // One extra bit for the most negative input
    logic [DATA_W:0] y;
    neg   = v[DATA_W-1];
    v_ext = {v[DATA_W-1], v};
    mag   = neg ? (~v_ext + 1'b1) : v_ext;
    if (mag < TH_LOW) begin
      y = mag;  // Linear near zero
    end else if (mag < TH_HIGH) begin
      y = (mag >> 1) + Y_QUART;  // Truncated half
    end else begin
      y = Y_ONE;  // Saturated
    end
    // y never exceeds 1.0 so the word holds it
    return neg ? (~y[DATA_W-1:0] + 1'b1) : y[DATA_W-1:0];
  endfunction

  gate_pkg::gate_vec_t a_next;

  always_comb begin
    for (int i = 0; i < `GATE_LANES; i++) begin
      a_next[i] = tanh_pwl(lane_res[i]);
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_out   <= '0;
      a_valid <= 1'b0;
    end else begin
      a_valid <= lane_valid;
      if (lane_valid) begin
        a_out <= a_next;  // Held until the next vector
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/gate_lane/gate_lane_mac.sv ====
// One multiply-accumulate lane; LANE_IDX must be below GATE_LANES and the result saturates to Q8.8
`timescale 1ns/1ps
`default_nettype none

`include "gate_defines.svh"

module gate_lane_mac #(
  parameter int LANE_IDX = 0  // Element handled by this lane
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire gate_pkg::lane_cmd_t  cmd,
  input  wire gate_pkg::gate_vec_t  bias_q,
  output gate_pkg::gate_data_t      lane_res,
  output logic                      lane_valid  // One cycle per vector
);

  localparam int DATA_W = `GATE_DATA_W;
  localparam int FRAC   = `GATE_FRAC;
  localparam int ACC_W  = `GATE_ACC_W;

  // Saturation limits of the output word
  localparam logic [DATA_W-1:0] RES_MAX = {1'b0, {(DATA_W-1){1'b1}}};
  localparam logic [DATA_W-1:0] RES_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  logic signed [2*DATA_W-1:0] prod;      // Q16.16
  logic signed [ACC_W-1:0]    bias_ext;  // Bias at product scale
  logic signed [ACC_W-1:0]    acc_q;
  logic signed [ACC_W-1:0]    acc_sum;
  logic signed [ACC_W-1:0]    acc_shr;   // Back to Q8.8
  logic [ACC_W-DATA_W:0]      acc_top;   // Bits above the word plus its sign
  logic                       in_range;
  gate_pkg::gate_data_t       res_sat;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  assign prod     = $signed(cmd.x) * $signed(cmd.weights[LANE_IDX]);
  assign bias_ext = ACC_W'($signed(bias_q[LANE_IDX])) <<< FRAC;  // Sign extend then align
  assign acc_sum  = acc_q + ACC_W'(prod);
  assign acc_shr  = acc_sum >>> FRAC;  // Arithmetic shift

  // Fits when all top bits copy the sign
  assign acc_top  = acc_shr[ACC_W-1:DATA_W-1];
  assign in_range = (&acc_top) | ~(|acc_top);

  always_comb begin
    if (in_range) begin
      res_sat = acc_shr[DATA_W-1:0];
    end else if (acc_shr[ACC_W-1]) begin
      res_sat = RES_MIN;  // Negative overflow
    end else begin
      res_sat = RES_MAX;
    end
  end

  //////////////////////////////////////////////////
  // Accumulator and result
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (cmd.clear) begin
      acc_q <= bias_ext;
    end else if (cmd.acc) begin
      acc_q <= acc_sum;
    end
    if (cmd.acc && cmd.last) begin
      lane_res <= res_sat;  // Includes the last product
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= cmd.acc && cmd.last;
    end
  end

endmodule

`default_nettype wire

// ==== hw/gate_sequencer.sv ====
// Term sequencer; start while busy and term_valid while idle are dropped and there is no back-pressure
`timescale 1ns/1ps
`default_nettype none

module gate_sequencer (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,       // One-cycle pulse
  input  wire gate_pkg::gate_vec_t   bias,        // Sampled with start
  input  wire logic                  term_valid,  // One beat per strobe
  input  wire gate_pkg::term_beat_t  term,
  output logic                       busy,
  output gate_pkg::lane_cmd_t        cmd,         // Registered broadcast
  output gate_pkg::gate_vec_t        bias_q
);

  //////////////////////////////////////////////////
  // Controller state
  //////////////////////////////////////////////////

  typedef enum logic {
    ST_IDLE,  // Waiting for start
    ST_ACC    // Forwarding term beats
  } seq_state_t;

  seq_state_t state;

  logic start_ok;  // Start accepted this cycle
  logic beat_ok;   // Beat accepted this cycle

  // Command strobes
  logic cmd_clear;
  logic cmd_acc;
  logic cmd_last;

  // Command payload
  gate_pkg::gate_data_t cmd_x;
  gate_pkg::gate_vec_t  cmd_w;

  assign start_ok = (state == ST_IDLE) && start;
  assign beat_ok  = (state == ST_ACC) && term_valid;
  assign busy     = (state == ST_ACC);

  //////////////////////////////////////////////////
  // FSM and strobes
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ST_IDLE;
      cmd_clear <= 1'b0;
      cmd_acc   <= 1'b0;
      cmd_last  <= 1'b0;
    end else begin
      // Strobes live one cycle
      cmd_clear <= start_ok;
      cmd_acc   <= beat_ok;
      cmd_last  <= beat_ok && term.last;

      case (state)
        ST_IDLE: begin
          if (start_ok) begin
            state <= ST_ACC;
          end
        end
        ST_ACC: begin
          // Falls on the edge that takes the last beat
          if (beat_ok && term.last) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Payload capture
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_ok) begin
      bias_q <= bias;  // Held for the clear in the next cycle
    end
    if (beat_ok) begin
      cmd_x <= term.x;
      cmd_w <= term.weights;
    end
  end

  // Pack the broadcast
  assign cmd = '{clear: cmd_clear, acc: cmd_acc, last: cmd_last, x: cmd_x, weights: cmd_w};

endmodule

`default_nettype wire

// ==== common/gate_pkg.sv ====
// Shared types of the activation gate; all values are signed Q8.8 and vectors are GATE_LANES wide
`default_nettype none

`include "gate_defines.svh"

package gate_pkg;

  //////////////////////////////////////////////////
  // Scalars and vectors
  //////////////////////////////////////////////////

  // One Q8.8 value
  typedef logic signed [`GATE_DATA_W-1:0] gate_data_t;

  // Element i sits at index i
  typedef gate_data_t [`GATE_LANES-1:0] gate_vec_t;

  //////////////////////////////////////////////////
  // Stream beats
  //////////////////////////////////////////////////

  // One term of the sum
  typedef struct packed {
    gate_data_t x;        // Shared scalar
    gate_vec_t  weights;  // One weight per output element
    logic       last;     // Final term of the vector
  } term_beat_t;

  // Broadcast from the sequencer to every lane
  typedef struct packed {
    logic       clear;    // Preload bias
    logic       acc;      // Add weight times x
    logic       last;     // Only with acc
    gate_data_t x;
    gate_vec_t  weights;
  } lane_cmd_t;

endpackage

`default_nettype wire

// ==== common/gate_defines.svh ====
// Sizes of the activation gate datapath; the accumulator must hold a full-scale sum of all terms
`ifndef GATE_DEFINES_SVH
`define GATE_DEFINES_SVH

//////////////////////////////////////////////////
// Vector geometry
//////////////////////////////////////////////////

`define GATE_LANES 4   // Output elements per vector

//////////////////////////////////////////////////
// Number format
//////////////////////////////////////////////////

`define GATE_DATA_W 16  // Signed Q8.8 word
`define GATE_FRAC   8   // Fraction bits of the word

// Products are Q16.16 so 40 bits leave 8 guard bits for the sum
`define GATE_ACC_W  40

`endif
